// File: project.f
hw/tag_pkg.sv
hw/replay_pkg.sv
hw/tag_trace_rom.sv
hw/tag_trace_replay.sv
hw/tag_master.sv
hw/tag_client.sv
hw/clock_downsample.sv
hw/gateway_cfg_top.sv
verification/gateway_cfg_sva.sv
verification/gateway_cfg_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --assert --top-module gateway_cfg_tb -f project.f \
    -o gateway_cfg_sim &&
  ./obj_dir/gateway_cfg_sim ||
  { echo "Simulation failed" >&2; exit 1; }

// File: verification/gateway_cfg_tb.sv
module gateway_cfg_tb;

  import tag_pkg::*;
  import replay_pkg::*;

  localparam int clk_period       = 100;
  localparam int drive_delay      = 10;
  localparam int slow_ratio       = 15;
  localparam int num_packets      = 4;
  localparam int fast_toggles     = 4;
  localparam int min_slow_toggles = 3;
  // Boot trace is about 80 cycles, the clock checks about 45 more
  localparam int watchdog_cycles  = 4 * (80 + 45);

  typedef struct packed {
    logic [tag_id_width-1:0]      id;
    logic [tag_payload_width-1:0] payload;
  } packet_s;

  logic       clk    = 1'b0;
  logic       arst_n = 1'b0;
  logic       tag_data;
  logic       done;
  logic       output_disable;
  logic [2:0] mon_sel;
  logic       io_clk;
  logic       core_clk;

  int                        cyc            = 0;
  logic                      started        = 1'b0;
  int                        bit_idx        = 0;
  logic                      gap_due        = 1'b0;
  logic [tag_packet_len-1:0] pkt_bits       = '0;
  int                        pkt_count      = 0;
  logic                      done_seen      = 1'b0;
  ds_ratio_t                 io_ratio_exp   = '0;
  ds_ratio_t                 core_ratio_exp = '0;
  ctrl_cfg_s                 ctrl_exp       = '0;
  ctrl_cfg_s                 ctrl_next      = '0;
  int                        ctrl_due       = 0;
  logic                      prev_done      = 1'b0;
  logic                      prev_clk [2]     = '{1'b0, 1'b0};
  logic                      fast_phase [2]   = '{1'b0, 1'b0};
  int                        last_toggle [2]  = '{0, 0};
  int                        half_exp [2]     = '{slow_ratio + 1, slow_ratio + 1};
  int                        slow_checked [2] = '{0, 0};
  int                        fast_checked [2] = '{0, 0};

  gateway_cfg_top gateway_cfg_top_inst (
    .clk              (clk),
    .arst_n_i         (arst_n),
    .tag_data_o       (tag_data),
    .done_o           (done),
    .output_disable_o (output_disable),
    .mon_sel_o        (mon_sel),
    .io_clk_o         (io_clk),
    .core_clk_o       (core_clk)
  );

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  //////////////////////////////////////////////////
  // Reference model

  // Node id and payload follow the start bit, both MSB first
  function automatic packet_s decode_packet(input logic [tag_packet_len-1:0] bits);
    packet_s pkt;
    pkt.id      = bits[tag_packet_len-2 -: tag_id_width];
    pkt.payload = bits[tag_payload_width-1:0];
    return pkt;
  endfunction

  function automatic ctrl_cfg_s predict_ctrl(input logic [tag_payload_width-1:0] payload);
    ctrl_cfg_s cfg;
    cfg.mon_sel        = payload[3:1];
    cfg.output_disable = payload[0];
    return cfg;
  endfunction

  function automatic int predict_half_period(input logic programmed, input ds_ratio_t ratio);
    return programmed ? int'(ratio) + 1 : slow_ratio + 1;
  endfunction

  // Boot trace in ROM order
  function automatic packet_s expected_packet(input int idx);
    packet_s pkt;
    case (idx)
      0:       pkt = '{node_io_ds_id, 8'd2};
      1:       pkt = '{node_core_ds_id, 8'd4};
      2:       pkt = '{node_ctrl_id, 8'h0b};
      default: pkt = '{node_ctrl_id, 8'h06};
    endcase
    return pkt;
  endfunction

  //////////////////////////////////////////////////
  // Checks

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1, "Check failed");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "Run aborted");
  endtask

  task automatic watch_serial_line();
    packet_s pkt;
    packet_s want;
    if (done_seen) begin
      check_value("done_o stays high", 1, int'(done));
    end
    if (done && !done_seen) begin
      done_seen = 1'b1;
      check_value("packets before done_o", num_packets, pkt_count);
      check_value("done_o outside a packet", 0, bit_idx);
    end
    if (done) begin
      check_value("tag_data_o idle after done", 0, int'(tag_data));
    end
    if (bit_idx == 0) begin
      // Every packet is followed by at least one idle bit
      if (gap_due) begin
        check_value("idle bit after packet", 0, int'(tag_data));
        gap_due = 1'b0;
      end
      if (tag_data) begin
        pkt_bits = tag_packet_len'(1);
        bit_idx  = 1;
      end
    end else begin
      pkt_bits = {pkt_bits[tag_packet_len-2:0], tag_data};
      bit_idx  = bit_idx + 1;
    end
    if (bit_idx == tag_packet_len) begin
      bit_idx = 0;
      gap_due = 1'b1;
      if (pkt_count >= num_packets) begin
        abort_run("Unexpected packet on tag_data_o after the boot trace");
      end
      pkt  = decode_packet(pkt_bits);
      want = expected_packet(pkt_count);
      check_value($sformatf("packet %0d node id", pkt_count), int'(want.id), int'(pkt.id));
      check_value($sformatf("packet %0d payload", pkt_count), int'(want.payload),
                  int'(pkt.payload));
      case (pkt.id)
        node_ctrl_id: begin
          ctrl_next = predict_ctrl(pkt.payload);
          ctrl_due  = cyc + 2;
        end
        node_io_ds_id:   io_ratio_exp   = pkt.payload;
        node_core_ds_id: core_ratio_exp = pkt.payload;
        default: begin
        end
      endcase
      pkt_count = pkt_count + 1;
    end
    // Old value until two cycles after the last bit
    if (ctrl_due != 0 && cyc == ctrl_due) begin
      ctrl_exp = ctrl_next;
      ctrl_due = 0;
    end
    check_value("output_disable_o", int'(ctrl_exp.output_disable), int'(output_disable));
    check_value("mon_sel_o", int'(ctrl_exp.mon_sel), int'(mon_sel));
  endtask

  task automatic watch_divided_clocks();
    logic      cur [2];
    ds_ratio_t ratio [2];
    string     name;
    int        i;
    cur[0]   = io_clk;
    cur[1]   = core_clk;
    ratio[0] = io_ratio_exp;
    ratio[1] = core_ratio_exp;
    for (i = 0; i < 2; i++) begin
      if (cur[i] != prev_clk[i]) begin
        if (i == 0) begin
          name = "io_clk_o half period";
        end else begin
          name = "core_clk_o half period";
        end
        check_value(name, half_exp[i], cyc - last_toggle[i]);
        if (fast_phase[i]) begin
          fast_checked[i] = fast_checked[i] + 1;
        end else begin
          slow_checked[i] = slow_checked[i] + 1;
        end
        // The ratio seen at this toggle sets the next half period
        last_toggle[i] = cyc;
        fast_phase[i]  = prev_done;
        half_exp[i]    = predict_half_period(prev_done, ratio[i]);
      end
      prev_clk[i] = cur[i];
    end
    prev_done = done;
  endtask

  // Sample in mid cycle
  always @(negedge clk) begin
    if (arst_n) begin
      if (!started) begin
        started        = 1'b1;
        last_toggle[0] = cyc;
        last_toggle[1] = cyc;
      end
      watch_serial_line();
      watch_divided_clocks();
    end
  end

  //////////////////////////////////////////////////
  // Reset, end of run and watchdog

  initial begin
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_value("tag_data_o in reset", 0, int'(tag_data));
    check_value("done_o in reset", 0, int'(done));
    check_value("output_disable_o in reset", 0, int'(output_disable));
    check_value("mon_sel_o in reset", 0, int'(mon_sel));
    check_value("io_clk_o in reset", 0, int'(io_clk));
    check_value("core_clk_o in reset", 0, int'(core_clk));
    @(posedge clk);
    #drive_delay;
    arst_n = 1'b1;
    while (fast_checked[0] < fast_toggles || fast_checked[1] < fast_toggles) begin
      @(posedge clk);
    end
    if (slow_checked[0] < min_slow_toggles || slow_checked[1] < min_slow_toggles) begin
      abort_run("Too few slow divided clock half periods seen before done_o");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    abort_run($sformatf("Timeout: run still going after %0d cycles", watchdog_cycles));
  end

endmodule

// File: verification/gateway_cfg_sva.sv
module gateway_cfg_sva (
  input logic clk,
  input logic arst_n_i,
  input logic tag_data_i,
  input logic done_i,
  input logic output_disable_i
);

  import tag_pkg::*;

  localparam logic [3:0] last_cnt = 4'(tag_packet_len - 1);

  logic [3:0] bit_cnt_r;
  logic       pkt_end;

  // Serial packet tracker, pkt_end marks the last payload bit
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bit_cnt_r <= '0;
    end else if (bit_cnt_r != '0) begin
      bit_cnt_r <= (bit_cnt_r == last_cnt) ? 4'd0 : bit_cnt_r + 1'b1;
    end else if (tag_data_i) begin
      bit_cnt_r <= 4'd1;
    end
  end

  assign pkt_end = (bit_cnt_r == last_cnt);

  idle_after_done_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    done_i |-> !tag_data_i) else $error("tag_data_o active while done_o is high");

  done_sticky_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    done_i |=> done_i) else $error("done_o fell after rising");

  // Client update lands two cycles after the packet's last bit
  od_update_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    $changed(output_disable_i) |-> $past(pkt_end, 2))
    else $error("output_disable_o changed away from a packet end");

endmodule

bind gateway_cfg_top gateway_cfg_sva gateway_cfg_sva_inst (
  .clk              (clk),
  .arst_n_i         (arst_n_i),
  .tag_data_i       (tag_data_o),
  .done_i           (done_o),
  .output_disable_i (output_disable_o)
);

// File: hw/gateway_cfg_top.sv
module gateway_cfg_top #(
  parameter replay_pkg::ds_ratio_t slow_ratio = 8'd15
) (
  input  logic       clk,
  input  logic       arst_n_i,
  output logic       tag_data_o,
  output logic       done_o,
  output logic       output_disable_o,
  output logic [2:0] mon_sel_o,
  output logic       io_clk_o,
  output logic       core_clk_o
);

  import tag_pkg::*;
  import replay_pkg::*;

  logic [rom_addr_width-1:0] rom_addr;
  replay_entry_s             rom_entry;
  tag_msg_s                  tag_msg;
  ctrl_cfg_s                 ctrl_cfg_r;
  ds_ratio_t                 io_ds_r;
  ds_ratio_t                 core_ds_r;
  ds_ratio_t                 io_ratio;
  ds_ratio_t                 core_ratio;

  //////////////////////////////////////////////////
  // Trace replay

  tag_trace_rom tag_trace_rom_inst (
    .addr_i  (rom_addr),
    .entry_o (rom_entry)
  );

  tag_trace_replay tag_trace_replay_inst (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .rom_addr_o (rom_addr),
    .entry_i    (rom_entry),
    .tag_data_o (tag_data_o),
    .done_o     (done_o)
  );

  //////////////////////////////////////////////////
  // Tag master and clients

  tag_master tag_master_inst (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .tag_data_i (tag_data_o),
    .msg_o      (tag_msg)
  );

  tag_client #(.payload_t(ctrl_cfg_s), .node_id(node_ctrl_id)) ctrl_client_inst (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .msg_i    (tag_msg),
    .data_r_o (ctrl_cfg_r)
  );

  tag_client #(.payload_t(ds_ratio_t), .node_id(node_io_ds_id)) io_ds_client_inst (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .msg_i    (tag_msg),
    .data_r_o (io_ds_r)
  );

  tag_client #(.payload_t(ds_ratio_t), .node_id(node_core_ds_id)) core_ds_client_inst (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .msg_i    (tag_msg),
    .data_r_o (core_ds_r)
  );

  assign output_disable_o = ctrl_cfg_r.output_disable;
  assign mon_sel_o        = ctrl_cfg_r.mon_sel;

  //////////////////////////////////////////////////
  // Divided clocks

  // Slow ratio while programming, programmed ratio after done
  assign io_ratio   = done_o ? io_ds_r : slow_ratio;
  assign core_ratio = done_o ? core_ds_r : slow_ratio;

  clock_downsample #(.slow_ratio(slow_ratio)) io_ds_inst (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .ratio_i  (io_ratio),
    .clk_r_o  (io_clk_o)
  );

  clock_downsample #(.slow_ratio(slow_ratio)) core_ds_inst (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .ratio_i  (core_ratio),
    .clk_r_o  (core_clk_o)
  );

endmodule

// File: hw/clock_downsample.sv
module clock_downsample #(
  parameter replay_pkg::ds_ratio_t slow_ratio = 8'd15
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  replay_pkg::ds_ratio_t ratio_i,
  output logic                  clk_r_o
);

  import replay_pkg::*;

  ds_ratio_t cnt_r;
  ds_ratio_t ratio_r;

  //////////////////////////////////////////////////
  // Half-period counter
  //
  // Output toggles every ratio+1 cycles. The ratio is
  // sampled only at a toggle so a new value never cuts
  // a phase short.

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_r   <= '0;
      ratio_r <= slow_ratio;
      clk_r_o <= 1'b0;
    end else begin
      if (cnt_r == ratio_r) begin
        cnt_r   <= '0;
        ratio_r <= ratio_i;
        clk_r_o <= ~clk_r_o;
      end else begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

endmodule

// File: hw/tag_client.sv
module tag_client #(
  parameter type                              payload_t = logic [7:0],
  parameter logic [tag_pkg::tag_id_width-1:0] node_id   = '0
) (
  input  logic              clk,
  input  logic              arst_n_i,
  input  tag_pkg::tag_msg_s msg_i,
  output payload_t          data_r_o
);

  localparam int payload_bits = $bits(payload_t);

  logic hit;

  // Every message reaches every client, the id picks the owner
  assign hit = msg_i.valid && (msg_i.id == node_id);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_r_o <= '0;
    end else if (hit) begin
      // Low bits of the payload only
      data_r_o <= payload_t'(msg_i.payload[payload_bits-1:0]);
    end
  end

endmodule

// File: hw/tag_master.sv
module tag_master (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              tag_data_i,
  output tag_pkg::tag_msg_s msg_o
);

  import tag_pkg::*;

  // Bits that follow the start bit
  localparam int body_bits = tag_packet_len - 1;

  logic                         busy_r;
  logic [3:0]                   bit_cnt_r;
  logic                         last_bit;
  logic [body_bits-1:0]         shift_r;
  logic [body_bits-1:0]         shift_next;
  logic                         valid_r;
  logic [tag_id_width-1:0]      id_r;
  logic [tag_payload_width-1:0] payload_r;

  assign shift_next = {shift_r[body_bits-2:0], tag_data_i};
  assign last_bit   = busy_r && (bit_cnt_r == 4'(body_bits - 1));

  //////////////////////////////////////////////////
  // Start detection and bit count

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_r    <= 1'b0;
      bit_cnt_r <= '0;
      valid_r   <= 1'b0;
    end else begin
      valid_r <= last_bit;
      if (!busy_r) begin
        // Idle zeros are ignored
        if (tag_data_i) begin
          busy_r    <= 1'b1;
          bit_cnt_r <= '0;
        end
      end else begin
        bit_cnt_r <= bit_cnt_r + 1'b1;
        if (last_bit) begin
          busy_r <= 1'b0;
        end
      end
    end
  end

  // Deserializer and message fields
  always_ff @(posedge clk) begin
    if (busy_r) begin
      shift_r <= shift_next;
    end
    if (last_bit) begin
      id_r      <= shift_next[body_bits-1 -: tag_id_width];
      payload_r <= shift_next[tag_payload_width-1:0];
    end
  end

  assign msg_o = '{valid: valid_r, id: id_r, payload: payload_r};

endmodule

// File: hw/tag_trace_replay.sv
module tag_trace_replay (
  input  logic                                  clk,
  input  logic                                  arst_n_i,
  output logic [replay_pkg::rom_addr_width-1:0] rom_addr_o,
  input  replay_pkg::replay_entry_s             entry_i,
  output logic                                  tag_data_o,
  output logic                                  done_o
);

  import tag_pkg::*;
  import replay_pkg::*;

  typedef enum logic [1:0] {
    st_fetch,
    st_shift,
    st_wait,
    st_finished
  } state_e;

  state_e                        state_r;
  logic [rom_addr_width-1:0]     addr_r;
  logic [tag_packet_len-1:0]     shift_r;
  logic [replay_arg_width-1:0]   cnt_r;

  //////////////////////////////////////////////////
  // Trace sequencer

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= st_fetch;
      addr_r  <= '0;
      shift_r <= '0;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        st_fetch: begin
          case (entry_i.op)
            op_send: begin
              shift_r <= {1'b1, entry_i.node_id, entry_i.arg};
              cnt_r   <= replay_arg_width'(tag_packet_len - 1);
              state_r <= st_shift;
            end
            op_wait: begin
              // A zero wait just moves on
              if (entry_i.arg == '0) begin
                addr_r <= addr_r + 1'b1;
              end else begin
                cnt_r   <= entry_i.arg - 1'b1;
                state_r <= st_wait;
              end
            end
            default: begin
              state_r <= st_finished;
            end
          endcase
        end
        st_shift: begin
          // Zeros shift in behind the packet, so the line idles low
          shift_r <= shift_r << 1;
          if (cnt_r == '0) begin
            addr_r  <= addr_r + 1'b1;
            state_r <= st_fetch;
          end else begin
            cnt_r <= cnt_r - 1'b1;
          end
        end
        st_wait: begin
          if (cnt_r == '0) begin
            addr_r  <= addr_r + 1'b1;
            state_r <= st_fetch;
          end else begin
            cnt_r <= cnt_r - 1'b1;
          end
        end
        default: begin
          state_r <= st_finished;
        end
      endcase
    end
  end

  assign rom_addr_o = addr_r;
  assign tag_data_o = shift_r[tag_packet_len-1];
  assign done_o     = (state_r == st_finished);

endmodule

// File: hw/tag_trace_rom.sv
module tag_trace_rom (
  input  logic [replay_pkg::rom_addr_width-1:0] addr_i,
  output replay_pkg::replay_entry_s             entry_o
);

  import tag_pkg::*;
  import replay_pkg::*;

  // Boot trace, everything past the last entry reads as finish
  always_comb begin
    entry_o = '{op: op_finish, node_id: '0, arg: '0};
    case (addr_i)
      4'd0: begin
        // io clock ratio
        entry_o = '{op: op_send, node_id: node_io_ds_id, arg: 8'd2};
      end
      4'd1: begin
        entry_o = '{op: op_wait, node_id: '0, arg: 8'd20};
      end
      4'd2: begin
        // core clock ratio
        entry_o = '{op: op_send, node_id: node_core_ds_id, arg: 8'd4};
      end
      4'd3: begin
        // Outputs disabled, monitor select 5
        entry_o = '{op: op_send, node_id: node_ctrl_id, arg: 8'h0b};
      end
      4'd4: begin
        entry_o = '{op: op_wait, node_id: '0, arg: 8'd5};
      end
      4'd5: begin
        // Outputs enabled, monitor select 3
        entry_o = '{op: op_send, node_id: node_ctrl_id, arg: 8'h06};
      end
      default: begin
        entry_o = '{op: op_finish, node_id: '0, arg: '0};
      end
    endcase
  end

endmodule

// File: hw/replay_pkg.sv
package replay_pkg;

  //////////////////////////////////////////////////
  // Boot trace format

  localparam int rom_addr_width   = 4;
  localparam int replay_arg_width = 8;

  typedef enum logic [1:0] {
    op_send   = 2'd0,
    op_wait   = 2'd1,
    op_finish = 2'd2
  } replay_op_e;

  // arg is the payload for a send, the idle cycle count for a wait
  typedef struct packed {
    replay_op_e                        op;
    logic [tag_pkg::tag_id_width-1:0]  node_id;
    logic [replay_arg_width-1:0]       arg;
  } replay_entry_s;

  //////////////////////////////////////////////////
  // Client payloads

  typedef struct packed {
    logic [2:0] mon_sel;
    logic       output_disable;
  } ctrl_cfg_s;

  typedef logic [7:0] ds_ratio_t;

endpackage

// File: hw/tag_pkg.sv
package tag_pkg;

  //////////////////////////////////////////////////
  // Serial tag protocol

  localparam int tag_id_width      = 2;
  localparam int tag_payload_width = 8;

  // Start bit, node id, payload
  localparam int tag_packet_len = 1 + tag_id_width + tag_payload_width;

  //////////////////////////////////////////////////
  // Node map

  localparam logic [tag_id_width-1:0] node_ctrl_id    = 2'd0;
  localparam logic [tag_id_width-1:0] node_io_ds_id   = 2'd1;
  localparam logic [tag_id_width-1:0] node_core_ds_id = 2'd2;

  // One decoded packet, valid for a single cycle
  typedef struct packed {
    logic                         valid;
    logic [tag_id_width-1:0]      id;
    logic [tag_payload_width-1:0] payload;
  } tag_msg_s;

endpackage
